/* flist.f */
+incdir+src
src/conv_pkg.sv
src/conv_cfg_regs.sv
src/conv_loop_fsm.sv
src/conv_addr_gen.sv
src/conv_ctrl_top.sv
verif/conv_ctrl_tb.sv

/* Bender.yml */
package:
  name: conv_ctrl

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/conv_pkg.sv
      - src/conv_cfg_regs.sv
      - src/conv_loop_fsm.sv
      - src/conv_addr_gen.sv
      - src/conv_ctrl_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/conv_ctrl_tb.sv

/* verif/conv_ctrl_tb.sv */
// ------------------------------------------------------------------
// Testbench for the convolution sequencer with random-latency
// responders for loaders, MAC and drain, and per-layer checks
// ------------------------------------------------------------------
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_ctrl_tb
    import conv_pkg::*;
();

    localparam int DIM   = `CONV_DIM;
    localparam int BLOCK = `CONV_CH_BLOCK;
    localparam int N_CFG = 5;

    // Expected bank and windows for one batch, channel and tile
    typedef struct packed {
        bank_t     bank;
        addr_win_t ifmap;
        addr_win_t weight;
        addr_win_t outw;
    } exp_win_t;

    logic       clk;
    logic       rst;
    logic       start;
    conv_cfg_t  cfg;
    logic [3:0] ack_vec;
    logic [3:0] req_vec;
    int         wait_cnt [4];

    logic       weight_req;
    logic       load_en;
    logic       load_restart;
    logic       run_start;
    logic       drain_en;
    bank_t      bank_sel;
    addr_win_t  ifmap_win;
    addr_win_t  weight_win;
    addr_win_t  out_win;
    logic       done_filter;
    logic       done_all;

    conv_cfg_t  cfgs [N_CFG];
    conv_cfg_t  cur_cfg;
    exp_win_t   mon_exp;
    int         cur_tiles;
    int         mon_b;
    int         mon_c;
    int         mon_t;
    int         n_weight;
    int         n_run;
    int         n_drain;
    int         n_restart;
    int         n_filter;
    int         n_done;
    int         errors;
    int         cycles;
    int         limit;
    logic       req_q;
    logic       load_q;
    logic       run_q;
    logic       drain_q;

    conv_ctrl_top DUT (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cfg          (cfg),
        .weight_ack   (ack_vec[0]),
        .load_done    (ack_vec[1]),
        .run_done     (ack_vec[2]),
        .drain_done   (ack_vec[3]),
        .weight_req   (weight_req),
        .load_en      (load_en),
        .load_restart (load_restart),
        .run_start    (run_start),
        .drain_en     (drain_en),
        .bank_sel     (bank_sel),
        .ifmap_win    (ifmap_win),
        .weight_win   (weight_win),
        .out_win      (out_win),
        .done_filter  (done_filter),
        .done_all     (done_all)
    );

    assign req_vec = {drain_en, run_start, load_en, weight_req};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic int out_len_of(input conv_cfg_t c);
        int s;
        int padded;
        s      = (c.stride == 0) ? 1 : int'(c.stride);
        padded = int'(c.temporal_length) + 2 * int'(c.padding);
        if (padded < int'(c.kernel_size)) begin
            return 0;
        end
        return (padded - int'(c.kernel_size)) / s + 1;
    endfunction

    function automatic exp_win_t expected_windows(input conv_cfg_t c, input int b,
                                                  input int ch, input int t);
        exp_win_t w;
        int       s;
        int       k;
        int       len;
        int       base;
        int       pos;
        int       olen;
        s    = (c.stride == 0) ? 1 : int'(c.stride);
        k    = int'(c.kernel_size);
        len  = int'(c.temporal_length);
        olen = out_len_of(c);
        base = (ch / DIM) * len;
        pos  = k * t * s - int'(c.padding);
        w.bank            = bank_t'(ch % DIM);
        w.ifmap.end_addr  = addr_t'(base + len - 1);
        if (pos < 0) begin
            w.ifmap.start_addr = addr_t'(base);
        end else if (pos >= len) begin
            w.ifmap.start_addr = addr_t'(base + len);
        end else begin
            w.ifmap.start_addr = addr_t'(base + pos);
        end
        w.weight.start_addr = addr_t'((ch % BLOCK) * k);
        w.weight.end_addr   = addr_t'((ch % BLOCK) * k + k - 1);
        w.outw.start_addr   = addr_t'(b * olen + t * DIM);
        w.outw.end_addr     = addr_t'(b * olen + olen - 1);
        return w;
    endfunction

    function automatic conv_cfg_t make_cfg(input int ch, input int f, input int len,
                                           input int k, input int s, input int p);
        conv_cfg_t c;
        c.in_channels     = cnt_t'(ch);
        c.filter_number   = cnt_t'(f);
        c.temporal_length = cnt_t'(len);
        c.kernel_size     = 5'(k);
        c.stride          = 2'(s);
        c.padding         = 3'(p);
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] t=%0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Loader, MAC and drain responders with 1 to 8 cycles of latency
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            ack_vec[i] <= 1'b0;
            if (req_vec[i] && !ack_vec[i]) begin
                if (wait_cnt[i] == 0) begin
                    wait_cnt[i] = $urandom_range(8, 1);
                end
                wait_cnt[i] = wait_cnt[i] - 1;
                if (wait_cnt[i] == 0) begin
                    ack_vec[i] <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Monitor for event counts and window checks at load and drain
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            req_q   <= 1'b0;
            load_q  <= 1'b0;
            run_q   <= 1'b0;
            drain_q <= 1'b0;
        end else begin
            req_q   <= weight_req;
            load_q  <= load_en;
            run_q   <= run_start;
            drain_q <= drain_en;
            if (weight_req && !req_q) n_weight++;
            if (run_start && !run_q) n_run++;
            if (drain_en && !drain_q) n_drain++;
            if (load_restart) n_restart++;
            if (done_filter) n_filter++;
            if (done_all) n_done++;
            // Step to the next tile, channel or batch when a drain ends
            if (!drain_en && drain_q) begin
                mon_t++;
                if (mon_t == cur_tiles) begin
                    mon_t = 0;
                    mon_c++;
                    if (mon_c == int'(cur_cfg.in_channels)) begin
                        mon_c = 0;
                        mon_b++;
                    end
                end
            end
            mon_exp = expected_windows(cur_cfg, mon_b, mon_c, mon_t);
            if (load_en && !load_q) begin
                check_value("bank_sel at load", bank_sel, mon_exp.bank);
                check_value("weight start at load", weight_win.start_addr,
                            mon_exp.weight.start_addr);
                check_value("weight end at load", weight_win.end_addr, mon_exp.weight.end_addr);
                check_value("ifmap start at load", ifmap_win.start_addr,
                            mon_exp.ifmap.start_addr);
                check_value("ifmap end at load", ifmap_win.end_addr, mon_exp.ifmap.end_addr);
            end
            if (drain_en && !drain_q) begin
                check_value("ifmap start at drain", ifmap_win.start_addr,
                            mon_exp.ifmap.start_addr);
                check_value("out start at drain", out_win.start_addr, mon_exp.outw.start_addr);
                check_value("out end at drain", out_win.end_addr, mon_exp.outw.end_addr);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Run timed out after %0d cycles, %0d errors so far", cycles, errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic run_layer(input conv_cfg_t c);
        int batches;
        int chans;
        chans     = int'(c.in_channels);
        batches   = (int'(c.filter_number) + DIM - 1) / DIM;
        cur_cfg   = c;
        cur_tiles = (out_len_of(c) + DIM - 1) / DIM;
        mon_b     = 0;
        mon_c     = 0;
        mon_t     = 0;
        n_weight  = 0;
        n_run     = 0;
        n_drain   = 0;
        n_restart = 0;
        n_filter  = 0;
        n_done    = 0;
        @(posedge clk);
        cfg   <= c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_value("weight_req after start", weight_req, 1);
        while (!done_all) @(posedge clk);
        repeat (3) @(posedge clk);
        check_value("weight requests", n_weight, batches * ((chans + BLOCK - 1) / BLOCK));
        check_value("MAC runs", n_run, batches * chans * cur_tiles);
        check_value("drains", n_drain, batches * chans * cur_tiles);
        check_value("load restarts", n_restart,
                    (cur_tiles > 0) ? batches * chans * (cur_tiles - 1) : 0);
        check_value("done_filter pulses", n_filter, batches);
        check_value("done_all pulses", n_done, 1);
    endtask

    initial begin
        void'($urandom(99));
        errors  = 0;
        cycles  = 0;
        rst     = 1'b0;
        start   = 1'b0;
        cfg     = '0;
        cur_cfg = '0;
        ack_vec = '0;
        for (int i = 0; i < 4; i++) begin
            wait_cnt[i] = 0;
        end
        cfgs[0] = make_cfg(70, 20, 40, 3, 2, 1);
        for (int i = 1; i < 3; i++) begin
            cfgs[i].in_channels     = cnt_t'($urandom_range(70, 1));
            cfgs[i].filter_number   = cnt_t'($urandom_range(40, 1));
            cfgs[i].temporal_length = cnt_t'($urandom_range(60, 1));
            cfgs[i].kernel_size     = 5'($urandom_range(7, 1));
            cfgs[i].stride          = 2'($urandom_range(3, 0));
            cfgs[i].padding         = 3'($urandom_range(3, 0));
        end
        // Second tile clamps to the channel end
        cfgs[3] = make_cfg(20, 8, 60, 23, 3, 7);
        // Kernel longer than the padded input leaves no tiles
        cfgs[4] = make_cfg(3, 5, 2, 7, 0, 1);
        limit = 1000;
        for (int i = 0; i < N_CFG; i++) begin
            limit += (int'(cfgs[i].filter_number) + DIM - 1) / DIM *
                     int'(cfgs[i].in_channels) * ((out_len_of(cfgs[i]) + DIM - 1) / DIM) * 40;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        check_value("control outputs after reset",
                    {weight_req, load_en, load_restart, run_start, drain_en, done_filter,
                     done_all}, 0);
        check_value("ifmap_win after reset", ifmap_win, 0);
        check_value("weight_win after reset", weight_win, 0);
        check_value("out_win after reset", out_win, 0);
        for (int i = 0; i < N_CFG; i++) begin
            run_layer(cfgs[i]);
        end
        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src/conv_ctrl_top.sv */
// ------------------------------------------------------------------
// Top level of the 1D convolution sequencer: configuration capture,
// loop control and address generation
// ------------------------------------------------------------------
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_ctrl_top
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  conv_cfg_t cfg,
    input  logic      weight_ack,
    input  logic      load_done,
    input  logic      run_done,
    input  logic      drain_done,
    output logic      weight_req,
    output logic      load_en,
    output logic      load_restart,
    output logic      run_start,
    output logic      drain_en,
    output bank_t     bank_sel,
    output addr_win_t ifmap_win,
    output addr_win_t weight_win,
    output addr_win_t out_win,
    output logic      done_filter,
    output logic      done_all
);

    conv_geom_t geom;
    logic       busy;
    logic       chan_setup;
    logic       tile_setup;
    cnt_t       tile_idx;
    cnt_t       chan_idx;
    cnt_t       batch_idx;

    conv_cfg_regs u_cfg_regs (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .cfg   (cfg),
        .geom  (geom)
    );

    conv_loop_fsm u_loop_fsm (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .geom         (geom),
        .weight_ack   (weight_ack),
        .load_done    (load_done),
        .run_done     (run_done),
        .drain_done   (drain_done),
        .busy         (busy),
        .weight_req   (weight_req),
        .load_en      (load_en),
        .load_restart (load_restart),
        .run_start    (run_start),
        .drain_en     (drain_en),
        .chan_setup   (chan_setup),
        .tile_setup   (tile_setup),
        .tile_idx     (tile_idx),
        .chan_idx     (chan_idx),
        .batch_idx    (batch_idx),
        .done_filter  (done_filter),
        .done_all     (done_all)
    );

    conv_addr_gen u_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .geom       (geom),
        .chan_setup (chan_setup),
        .tile_setup (tile_setup),
        .tile_idx   (tile_idx),
        .chan_idx   (chan_idx),
        .batch_idx  (batch_idx),
        .bank_sel   (bank_sel),
        .ifmap_win  (ifmap_win),
        .weight_win (weight_win),
        .out_win    (out_win)
    );

endmodule

/* src/conv_addr_gen.sv */
// ------------------------------------------------------------------
// Address windows and input bank select for the current channel and
// tile, updated one cycle after the sequencer strobes
// ------------------------------------------------------------------
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_addr_gen
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  conv_geom_t geom,
    input  logic       chan_setup,
    input  logic       tile_setup,
    input  cnt_t       tile_idx,
    input  cnt_t       chan_idx,
    input  cnt_t       batch_idx,
    output bank_t      bank_sel,
    output addr_win_t  ifmap_win,
    output addr_win_t  weight_win,
    output addr_win_t  out_win
);

    addr_t              in_base;
    addr_t              out_base;
    addr_t              chan_in_base;
    addr_t              chan_w_base;
    addr_t              chan_out_base;
    logic [19:0]        tile_prod;
    logic signed [20:0] tile_pos;
    addr_t              tile_in_start;
    addr_t              tile_out_start;

    // ------------------------------------------------------------------
    // Channel bases
    // ------------------------------------------------------------------
    always_comb begin
        // DIM channels share one bank row and stack by temporal length
        chan_in_base  = addr_t'((chan_idx / `CONV_DIM) * geom.temporal_length);
        // Weight memory restarts every weight block
        chan_w_base   = addr_t'((chan_idx % `CONV_CH_BLOCK) * geom.kernel_size);
        chan_out_base = addr_t'(batch_idx * geom.output_length);
    end

    // ------------------------------------------------------------------
    // Tile start with the input position clamped into the channel
    // ------------------------------------------------------------------
    always_comb begin
        tile_prod = geom.kernel_size * tile_idx * geom.stride_eff;
        tile_pos  = $signed({1'b0, tile_prod}) - $signed({18'd0, geom.padding});
        if (tile_pos < 0) begin
            tile_in_start = in_base;
        end else if (tile_pos >= $signed({11'd0, geom.temporal_length})) begin
            tile_in_start = in_base + geom.temporal_length;
        end else begin
            tile_in_start = in_base + tile_pos[`CONV_ADDR_W-1:0];
        end
        tile_out_start = out_base + addr_t'(tile_idx * `CONV_DIM);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank_sel   <= '0;
            in_base    <= '0;
            out_base   <= '0;
            ifmap_win  <= '0;
            weight_win <= '0;
            out_win    <= '0;
        end else if (chan_setup) begin
            bank_sel              <= bank_t'(chan_idx % `CONV_DIM);
            in_base               <= chan_in_base;
            out_base              <= chan_out_base;
            ifmap_win.start_addr  <= chan_in_base;
            ifmap_win.end_addr    <= chan_in_base + geom.temporal_length - 1'b1;
            weight_win.start_addr <= chan_w_base;
            weight_win.end_addr   <= chan_w_base + geom.kernel_size - 1'b1;
            out_win.start_addr    <= chan_out_base;
            out_win.end_addr      <= addr_t'(chan_out_base + geom.output_length - 1'b1);
        end else if (tile_setup) begin
            // Ends stay at the channel limits
            ifmap_win.start_addr <= tile_in_start;
            out_win.start_addr   <= tile_out_start;
        end
    end

    // Empty output range only occurs when the layer has no tiles
    // A clamped tile start may sit one past the input window end
    a_win_order: assert property (@(posedge clk) disable iff (!rst)
        (chan_setup || tile_setup) && (geom.out_tiles != '0) |=>
            ({1'b0, ifmap_win.end_addr} + 1'b1 >= {1'b0, ifmap_win.start_addr}) &&
            (weight_win.end_addr >= weight_win.start_addr) &&
            (out_win.end_addr >= out_win.start_addr))
        else $error("address window end below its start");

endmodule

/* src/conv_loop_fsm.sv */
// ------------------------------------------------------------------
// Layer sequencer: batch, channel and tile loops around weight loads,
// tile loads, MAC runs and output drains
// ------------------------------------------------------------------
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_loop_fsm
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  conv_geom_t geom,
    input  logic       weight_ack,
    input  logic       load_done,
    input  logic       run_done,
    input  logic       drain_done,
    output logic       busy,
    output logic       weight_req,
    output logic       load_en,
    output logic       load_restart,
    output logic       run_start,
    output logic       drain_en,
    output logic       chan_setup,
    output logic       tile_setup,
    output cnt_t       tile_idx,
    output cnt_t       chan_idx,
    output cnt_t       batch_idx,
    output logic       done_filter,
    output logic       done_all
);

    seq_state_t state;
    seq_state_t state_nxt;

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_nxt = S_WEIGHT_REQ;
                end
            end
            S_WEIGHT_REQ: begin
                if (weight_ack) begin
                    state_nxt = S_CHAN_SETUP;
                end
            end
            // No tiles means nothing to compute for this channel
            S_CHAN_SETUP: begin
                state_nxt = (geom.out_tiles == '0) ? S_CHAN_INC : S_CHAN_SETTLE_A;
            end
            S_CHAN_SETTLE_A: state_nxt = S_CHAN_SETTLE_B;
            S_CHAN_SETTLE_B: state_nxt = S_LOAD;
            S_LOAD: begin
                if (load_done) begin
                    state_nxt = S_RUN;
                end
            end
            S_RUN: begin
                if (run_done) begin
                    state_nxt = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (drain_done) begin
                    state_nxt = S_TILE_INC;
                end
            end
            S_TILE_INC: state_nxt = S_TILE_CHECK;
            S_TILE_CHECK: begin
                state_nxt = (len_t'(tile_idx) < geom.out_tiles) ? S_TILE_SETUP : S_CHAN_INC;
            end
            S_TILE_SETUP:  state_nxt = S_TILE_SETTLE;
            S_TILE_SETTLE: state_nxt = S_RESTART;
            S_RESTART:     state_nxt = S_LOAD;
            S_CHAN_INC:    state_nxt = S_CHAN_CHECK;
            // Count already advanced, so a zero remainder opens a new weight block
            S_CHAN_CHECK: begin
                if (chan_idx < geom.in_channels) begin
                    if ((chan_idx % `CONV_CH_BLOCK) == 0) begin
                        state_nxt = S_WEIGHT_REQ;
                    end else begin
                        state_nxt = S_CHAN_SETUP;
                    end
                end else begin
                    state_nxt = S_BATCH_INC;
                end
            end
            S_BATCH_INC: state_nxt = S_BATCH_CHECK;
            S_BATCH_CHECK: begin
                state_nxt = (len_t'(batch_idx) < geom.filter_batches) ? S_WEIGHT_REQ : S_DONE;
            end
            S_DONE:  state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Loop counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tile_idx  <= '0;
            chan_idx  <= '0;
            batch_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        tile_idx  <= '0;
                        chan_idx  <= '0;
                        batch_idx <= '0;
                    end
                end
                S_TILE_INC: tile_idx <= tile_idx + 1'b1;
                S_CHAN_INC: begin
                    chan_idx <= chan_idx + 1'b1;
                    tile_idx <= '0;
                end
                S_BATCH_INC: begin
                    batch_idx <= batch_idx + 1'b1;
                    chan_idx  <= '0;
                end
                default: ;
            endcase
        end
    end

    // Control levels and strobes decoded from the state
    assign busy         = (state != S_IDLE);
    assign weight_req   = (state == S_WEIGHT_REQ);
    assign chan_setup   = (state == S_CHAN_SETUP);
    assign tile_setup   = (state == S_TILE_SETUP);
    assign load_restart = (state == S_RESTART);
    assign load_en      = (state == S_LOAD);
    assign run_start    = (state == S_RUN);
    assign drain_en     = (state == S_DRAIN);
    assign done_filter  = (state == S_BATCH_CHECK);
    assign done_all     = (state == S_DONE);

    a_req_load_excl: assert property (@(posedge clk) disable iff (!rst)
        !(weight_req && load_en))
        else $error("weight request overlaps a tile load");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_all |=> !done_all)
        else $error("done_all longer than one cycle");

    a_drain_tile: assert property (@(posedge clk) disable iff (!rst)
        drain_en |-> (len_t'(tile_idx) < geom.out_tiles))
        else $error("drain beyond the last output tile");

endmodule

/* src/conv_cfg_regs.sv */
// ------------------------------------------------------------------
// Captures the layer configuration on start and holds the derived
// geometry for the sequencer and the address generator
// ------------------------------------------------------------------
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_cfg_regs
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       busy,
    input  conv_cfg_t  cfg,
    output conv_geom_t geom
);

    logic       capture;
    logic [2:0] stride_eff;
    len_t       padded_len;
    len_t       output_length;
    len_t       out_tiles;
    len_t       filter_batches;

    assign capture = start && !busy;

    // Stride of zero behaves as one
    assign stride_eff = (cfg.stride == 2'd0) ? 3'd1 : {1'b0, cfg.stride};

    assign padded_len = len_t'(cfg.temporal_length) + (len_t'(cfg.padding) << 1);

    // Kernel longer than the padded input gives no outputs at all
    assign output_length = (padded_len >= len_t'(cfg.kernel_size)) ?
        (padded_len - len_t'(cfg.kernel_size)) / len_t'(stride_eff) + len_t'(1) : '0;

    assign out_tiles      = (output_length + len_t'(`CONV_DIM - 1)) / len_t'(`CONV_DIM);
    assign filter_batches = (len_t'(cfg.filter_number) + len_t'(`CONV_DIM - 1)) /
                            len_t'(`CONV_DIM);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            geom <= '0;
        end else if (capture) begin
            geom.stride          <= cfg.stride;
            geom.padding         <= cfg.padding;
            geom.kernel_size     <= cfg.kernel_size;
            geom.in_channels     <= cfg.in_channels;
            geom.filter_number   <= cfg.filter_number;
            geom.temporal_length <= cfg.temporal_length;
            geom.stride_eff      <= stride_eff;
            geom.output_length   <= output_length;
            geom.out_tiles       <= out_tiles;
            geom.filter_batches  <= filter_batches;
        end
    end

    // Geometry frozen for the whole layer once the sequencer is running
    a_geom_stable: assert property (@(posedge clk) disable iff (!rst)
        busy && $past(busy) |-> $stable(geom))
        else $error("geometry changed during a layer");

endmodule

/* src/conv_pkg.sv */
// ------------------------------------------------------------------
// Shared types of the convolution sequencer: layer configuration,
// derived geometry, address windows and sequencer states
// ------------------------------------------------------------------
`include "conv_defines.svh"

package conv_pkg;

    typedef logic [`CONV_ADDR_W-1:0] addr_t;
    typedef logic [`CONV_CNT_W-1:0]  cnt_t;
    typedef logic [`CONV_LEN_W-1:0]  len_t;
    typedef logic [`CONV_BANK_W-1:0] bank_t;

    // Layer configuration as presented with start
    typedef struct packed {
        logic [1:0] stride;
        logic [2:0] padding;
        logic [4:0] kernel_size;
        cnt_t       in_channels;
        cnt_t       filter_number;
        cnt_t       temporal_length;
    } conv_cfg_t;

    // Registered configuration plus derived loop bounds
    typedef struct packed {
        logic [1:0] stride;
        logic [2:0] padding;
        logic [4:0] kernel_size;
        cnt_t       in_channels;
        cnt_t       filter_number;
        cnt_t       temporal_length;
        logic [2:0] stride_eff;
        len_t       output_length;
        len_t       out_tiles;
        len_t       filter_batches;
    } conv_geom_t;

    // Inclusive address range for one memory
    typedef struct packed {
        addr_t start_addr;
        addr_t end_addr;
    } addr_win_t;

    typedef enum logic [4:0] {
        S_IDLE,
        S_WEIGHT_REQ,
        S_CHAN_SETUP,
        S_CHAN_SETTLE_A,
        S_CHAN_SETTLE_B,
        S_LOAD,
        S_RUN,
        S_DRAIN,
        S_TILE_INC,
        S_TILE_CHECK,
        S_TILE_SETUP,
        S_TILE_SETTLE,
        S_RESTART,
        S_CHAN_INC,
        S_CHAN_CHECK,
        S_BATCH_INC,
        S_BATCH_CHECK,
        S_DONE
    } seq_state_t;

endpackage

/* src/conv_defines.svh */
// ------------------------------------------------------------------
// Widths and block sizes of the convolution sequencer, included by
// the package and by every RTL file
// ------------------------------------------------------------------
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Lanes per tile, also filters per batch
`define CONV_DIM 16

// Memory address width
`define CONV_ADDR_W 10

// Channel, filter and length fields of the configuration
`define CONV_CNT_W 10

// Derived lengths, wide enough for the padded input
`define CONV_LEN_W 12

// Channels held in weight memory per load
`define CONV_CH_BLOCK 64

// Input bank select, log2 of CONV_DIM
`define CONV_BANK_W 4

`endif
